// ==== hdl/mrd_macros.svh ====
// Shared widths and sizes for the mixed-radix transform processor
// Sample widths, RAM address width, packet size limits, sink timeout

`ifndef MRD_MACROS_SVH
`define MRD_MACROS_SVH

// Input sample width, real and imag each
`define MRD_IN_W 16

// Internal and output sample width
// 8 guard bits cover growth of 64x over three passes
`define MRD_DATA_W 24

// RAM addressing, one complex word per point
`define MRD_ADDR_W 6
`define MRD_MAX_PTS 64

// Up to three radix-2/4 factors per packet
`define MRD_MAX_PASS 3

// Idle cycles during sink before the packet is dropped
`define MRD_SINK_TIMEOUT 32

`endif

// ==== hdl/mrd_pkg.sv ====
// Package for the mixed-radix transform processor
// Controller state enum and radix opcode enum

`default_nettype none

package mrd_pkg;

	// ------------------------------------------------------------
	// Controller states
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		ST_IDLE    = 3'd0,
		ST_SINK    = 3'd1,
		ST_PASS    = 3'd2,
		ST_WAIT_WR = 3'd3,
		ST_SOURCE  = 3'd4
	} mrd_state_e;

	// Radix of one pass, matches one bit of cfg_radix
	typedef enum logic {
		RDX2 = 1'b0,
		RDX4 = 1'b1
	} mrd_radix_e;

endpackage

`default_nettype wire

// ==== hdl/mrd_ram.sv ====
// Simple dual-port packet RAM, single clock
// Write-first on address collision, registered read data

`timescale 1ns/1ps
`default_nettype none

`include "mrd_macros.svh"

module mrd_ram (
	input  wire                          clk,
	input  wire                          wr_en,
	input  wire  [`MRD_ADDR_W-1:0]       wr_addr,
	input  wire  [2*`MRD_DATA_W-1:0]     wr_data,
	input  wire                          rd_en,
	input  wire  [`MRD_ADDR_W-1:0]       rd_addr,
	output logic [2*`MRD_DATA_W-1:0]     rd_data
);

	// One complex word per point, {real, imag}
	logic [2*`MRD_DATA_W-1:0] mem [0:`MRD_MAX_PTS-1];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		// Same-cycle write to the read address is bypassed
		if (rd_en)
			rd_data <= (wr_en && wr_addr == rd_addr) ? wr_data : mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== hdl/mrd_io_addr.sv ====
// Sink and source address generator
// Sink write addresses, idle timeout abort
// Source read addresses, output valid/sop/eop framing

`timescale 1ns/1ps
`default_nettype none

`include "mrd_macros.svh"

module mrd_io_addr import mrd_pkg::*; (
	input  wire                        clk,
	input  wire                        rst_n,
	input  mrd_state_e                 state,
	input  wire                        in_valid,
	input  wire  [`MRD_ADDR_W:0]       num_pts,
	output logic                       sink_wr_en,
	output logic [`MRD_ADDR_W-1:0]     sink_wr_addr,
	output logic                       sink_done,
	output logic                       sink_abort,
	output logic                       src_rd_en,
	output logic [`MRD_ADDR_W-1:0]     src_rd_addr,
	output logic                       src_done,
	output logic                       out_valid,
	output logic                       out_sop,
	output logic                       out_eop
);

	// Shared point counter, samples in sink, reads in source
	logic [`MRD_ADDR_W:0] cnt;
	// Cycles since the last valid sample
	logic [5:0]           idle_cnt;

	// ------------------------------------------------------------
	// Sink side
	// ------------------------------------------------------------
	assign sink_wr_en   = (state == ST_SINK) && in_valid;
	assign sink_wr_addr = cnt[`MRD_ADDR_W-1:0];
	assign sink_done    = sink_wr_en && (cnt == num_pts - 1'b1);
	assign sink_abort   = (state == ST_SINK) && !in_valid &&
		(idle_cnt == 6'(`MRD_SINK_TIMEOUT - 1));

	// ------------------------------------------------------------
	// Source side
	// ------------------------------------------------------------
	// Stop reading once all N points are issued
	assign src_rd_en   = (state == ST_SOURCE) && (cnt < num_pts);
	assign src_rd_addr = cnt[`MRD_ADDR_W-1:0];
	// Leave source right after the last sample
	assign src_done    = out_eop;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt       <= '0;
			idle_cnt  <= '0;
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
		end else begin
			if (sink_wr_en || src_rd_en)
				cnt <= cnt + 1'b1;
			else if (state != ST_SINK && state != ST_SOURCE)
				cnt <= '0;
			// Idle counter only runs during sink
			if (state != ST_SINK || in_valid)
				idle_cnt <= '0;
			else
				idle_cnt <= idle_cnt + 1'b1;
			// Framing lines up with RAM read latency
			out_valid <= src_rd_en;
			out_sop   <= src_rd_en && (cnt == '0);
			out_eop   <= src_rd_en && (cnt == num_pts - 1'b1);
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mrd_pass_addr.sv ====
// In-place pass address generator
// Group read addresses in digit order for one radix pass
// Delay line for write addresses, read and write done flags

`timescale 1ns/1ps
`default_nettype none

`include "mrd_macros.svh"

module mrd_pass_addr import mrd_pkg::*; (
	input  wire                        clk,
	input  wire                        rst_n,
	input  mrd_state_e                 state,
	input  wire  [`MRD_ADDR_W:0]       num_pts,
	input  wire  [`MRD_ADDR_W-1:0]     stride,
	input  mrd_radix_e                 radix,
	output logic                       rd_en,
	output logic [`MRD_ADDR_W-1:0]     rd_addr,
	output logic                       rd_done,
	output logic                       wr_en,
	output logic [`MRD_ADDR_W-1:0]     wr_addr,
	output logic                       wr_done
);

	logic [`MRD_ADDR_W:0]   rd_cnt;
	logic [`MRD_ADDR_W:0]   wr_cnt;
	// Counter split, digit fastest, then inner, then outer
	logic [1:0]             digit;
	logic [`MRD_ADDR_W-1:0] rest;
	logic [`MRD_ADDR_W-1:0] inner;
	logic [`MRD_ADDR_W-1:0] outer_s;
	// Read-to-write delay line, six stages covers radix 4
	logic [5:0]                        en_sh;
	logic [5:0][`MRD_ADDR_W-1:0]       addr_sh;
	logic [2:0]                        tap;

	// ------------------------------------------------------------
	// Read address
	// ------------------------------------------------------------
	assign rd_en   = (state == ST_PASS);
	assign rd_done = rd_en && (rd_cnt == num_pts - 1'b1);

	always_comb begin
		if (radix == RDX4) begin
			digit = rd_cnt[1:0];
			rest  = rd_cnt[`MRD_ADDR_W-1:0] >> 2;
		end else begin
			digit = {1'b0, rd_cnt[0]};
			rest  = rd_cnt[`MRD_ADDR_W-1:0] >> 1;
		end
		// Stride is a power of two, so masks split inner and outer
		inner   = rest & (stride - 1'b1);
		outer_s = rest & ~(stride - 1'b1);
		// outer*stride*r + digit*stride + inner
		if (radix == RDX4)
			rd_addr = (outer_s << 2) + digit * stride + inner;
		else
			rd_addr = (outer_s << 1) + digit * stride + inner;
	end

	// ------------------------------------------------------------
	// Write address, read delayed by r+2 cycles
	// ------------------------------------------------------------
	// RAM latency 1 plus core latency r+1
	assign tap     = (radix == RDX4) ? 3'd5 : 3'd3;
	assign wr_en   = en_sh[tap];
	assign wr_addr = addr_sh[tap];
	assign wr_done = wr_en && (wr_cnt == num_pts - 1'b1);

	always_ff @(posedge clk) begin
		addr_sh <= {addr_sh[4:0], rd_addr};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_cnt <= '0;
			wr_cnt <= '0;
			en_sh  <= '0;
		end else begin
			if (rd_en)
				rd_cnt <= rd_cnt + 1'b1;
			else
				rd_cnt <= '0;
			// Flush stale stages so a radix change cannot tap them
			if (wr_done) begin
				wr_cnt <= '0;
				en_sh  <= '0;
			end else begin
				if (wr_en)
					wr_cnt <= wr_cnt + 1'b1;
				en_sh <= {en_sh[4:0], rd_en};
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mrd_rdx24_core.sv ====
// Streaming radix-2/radix-4 DFT kernel
// Double-buffered group collector, one output per cycle
// Output m of a group leaves r+1 cycles after input m

`timescale 1ns/1ps
`default_nettype none

`include "mrd_macros.svh"

module mrd_rdx24_core import mrd_pkg::*; (
	input  wire                               clk,
	input  wire                               rst_n,
	input  mrd_radix_e                        radix,
	input  wire                               in_valid,
	input  wire  signed [`MRD_DATA_W-1:0]     in_real,
	input  wire  signed [`MRD_DATA_W-1:0]     in_imag,
	output logic                              out_valid,
	output logic signed [`MRD_DATA_W-1:0]     out_real,
	output logic signed [`MRD_DATA_W-1:0]     out_imag
);

	// Two banks of four complex samples
	logic signed [`MRD_DATA_W-1:0] bank_re [0:1][0:3];
	logic signed [`MRD_DATA_W-1:0] bank_im [0:1][0:3];
	logic       fill_sel;
	logic [1:0] fcnt;
	logic [1:0] ecnt;
	logic       e_act;
	logic [1:0] r_last;
	logic       grp_done;
	// Radix-4 partial sums
	logic signed [`MRD_DATA_W-1:0] a_re, a_im, b_re, b_im;
	logic signed [`MRD_DATA_W-1:0] c_re, c_im, d_re, d_im;
	logic signed [`MRD_DATA_W-1:0] y_re, y_im;

	assign r_last   = (radix == RDX4) ? 2'd3 : 2'd1;
	assign grp_done = in_valid && (fcnt == r_last);

	// ------------------------------------------------------------
	// Collector
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (in_valid) begin
			bank_re[fill_sel][fcnt] <= in_real;
			bank_im[fill_sel][fcnt] <= in_imag;
		end
	end

	// ------------------------------------------------------------
	// Kernel on the emit bank
	// ------------------------------------------------------------
	always_comb begin
		a_re = bank_re[~fill_sel][0] + bank_re[~fill_sel][2];
		a_im = bank_im[~fill_sel][0] + bank_im[~fill_sel][2];
		b_re = bank_re[~fill_sel][0] - bank_re[~fill_sel][2];
		b_im = bank_im[~fill_sel][0] - bank_im[~fill_sel][2];
		c_re = bank_re[~fill_sel][1] + bank_re[~fill_sel][3];
		c_im = bank_im[~fill_sel][1] + bank_im[~fill_sel][3];
		d_re = bank_re[~fill_sel][1] - bank_re[~fill_sel][3];
		d_im = bank_im[~fill_sel][1] - bank_im[~fill_sel][3];
		if (radix == RDX2) begin
			// Plain butterfly on slots 0 and 1
			y_re = ecnt[0] ? bank_re[~fill_sel][0] - bank_re[~fill_sel][1]
				: bank_re[~fill_sel][0] + bank_re[~fill_sel][1];
			y_im = ecnt[0] ? bank_im[~fill_sel][0] - bank_im[~fill_sel][1]
				: bank_im[~fill_sel][0] + bank_im[~fill_sel][1];
		end else begin
			// Times -j is swap then negate imag
			case (ecnt)
				2'd0: begin
					y_re = a_re + c_re;
					y_im = a_im + c_im;
				end
				2'd1: begin
					y_re = b_re + d_im;
					y_im = b_im - d_re;
				end
				2'd2: begin
					y_re = a_re - c_re;
					y_im = a_im - c_im;
				end
				default: begin
					y_re = b_re - d_im;
					y_im = b_im + d_re;
				end
			endcase
		end
	end

	// Output samples carry no reset
	always_ff @(posedge clk) begin
		out_real <= y_re;
		out_imag <= y_im;
	end

	// ------------------------------------------------------------
	// Control
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fcnt      <= '0;
			fill_sel  <= 1'b0;
			e_act     <= 1'b0;
			ecnt      <= '0;
			out_valid <= 1'b0;
		end else begin
			if (grp_done) begin
				fcnt     <= '0;
				fill_sel <= ~fill_sel;
			end else if (in_valid) begin
				fcnt <= fcnt + 1'b1;
			end
			// New group restarts emission, previous one just ended
			if (grp_done) begin
				e_act <= 1'b1;
				ecnt  <= '0;
			end else if (e_act) begin
				if (ecnt == r_last)
					e_act <= 1'b0;
				ecnt <= ecnt + 1'b1;
			end
			out_valid <= e_act;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mrd_mem_ctrl.sv ====
// Packet memory controller
// Controller FSM, configuration capture, N and stride per pass
// Packet RAM with port switching between sink/source and pass addresses

`timescale 1ns/1ps
`default_nettype none

`include "mrd_macros.svh"

module mrd_mem_ctrl import mrd_pkg::*; (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          in_sop,
	input  wire                          in_valid,
	input  wire  [`MRD_IN_W-1:0]         in_real,
	input  wire  [`MRD_IN_W-1:0]         in_imag,
	input  wire  [1:0]                   cfg_num_pass,
	input  wire  [2:0]                   cfg_radix,
	output logic                         sink_ready,
	output mrd_state_e                   state,
	output logic                         core_in_valid,
	output logic [`MRD_DATA_W-1:0]       core_in_real,
	output logic [`MRD_DATA_W-1:0]       core_in_imag,
	output mrd_radix_e                   core_radix,
	input  wire                          core_out_valid,
	input  wire  [`MRD_DATA_W-1:0]       core_out_real,
	input  wire  [`MRD_DATA_W-1:0]       core_out_imag,
	output logic                         out_valid,
	output logic                         out_sop,
	output logic                         out_eop,
	output logic [`MRD_DATA_W-1:0]       out_real,
	output logic [`MRD_DATA_W-1:0]       out_imag
);

	logic accept;
	logic [1:0] num_pass_q;
	logic [2:0] radix_q;
	logic [1:0] pass_q;
	logic [`MRD_ADDR_W:0]   num_pts;
	logic [`MRD_ADDR_W-1:0] stride;
	// Input stage, sop sample lands in the first sink cycle
	logic                   in_valid_r;
	logic [`MRD_IN_W-1:0]   in_real_r, in_imag_r;
	// Address generator outputs
	logic sink_wr_en, sink_done, sink_abort, src_rd_en, src_done;
	logic [`MRD_ADDR_W-1:0] sink_wr_addr, src_rd_addr;
	logic pa_rd_en, pa_rd_done, pa_wr_en, pa_wr_done;
	logic [`MRD_ADDR_W-1:0] pa_rd_addr, pa_wr_addr;
	// RAM ports
	logic ram_wr_en, ram_rd_en;
	logic [`MRD_ADDR_W-1:0]   ram_wr_addr, ram_rd_addr;
	logic [2*`MRD_DATA_W-1:0] ram_wr_data, ram_rd_data;

	// log2 of the product of the first cnt radices
	function automatic logic [2:0] lg_sum(input logic [2:0] rdx, input logic [1:0] cnt);
		logic [2:0] acc;
		acc = 3'd0;
		for (int k = 0; k < `MRD_MAX_PASS; k++) begin
			if (k < cnt)
				acc = acc + (rdx[k] ? 3'd2 : 3'd1);
		end
		return acc;
	endfunction

	assign sink_ready = (state == ST_IDLE);
	assign accept     = sink_ready && in_sop && in_valid;
	assign num_pts    = {{`MRD_ADDR_W{1'b0}}, 1'b1} << lg_sum(radix_q, num_pass_q);
	assign stride     = {{(`MRD_ADDR_W-1){1'b0}}, 1'b1} << lg_sum(radix_q, pass_q);
	assign core_radix = radix_q[pass_q] ? RDX4 : RDX2;

	// ------------------------------------------------------------
	// FSM and configuration
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			num_pass_q <= 2'd1;
			radix_q    <= '0;
			pass_q     <= '0;
			in_valid_r <= 1'b0;
		end else begin
			in_valid_r <= in_valid;
			if (accept) begin
				num_pass_q <= cfg_num_pass;
				radix_q    <= cfg_radix;
				pass_q     <= '0;
			end
			case (state)
				ST_IDLE:
					if (accept)
						state <= ST_SINK;
				ST_SINK:
					if (sink_done)
						state <= ST_PASS;
					else if (sink_abort)
						state <= ST_IDLE;
				ST_PASS:
					if (pa_rd_done)
						state <= ST_WAIT_WR;
				ST_WAIT_WR:
					if (pa_wr_done) begin
						pass_q <= pass_q + 1'b1;
						state  <= (pass_q == num_pass_q - 1'b1) ? ST_SOURCE : ST_PASS;
					end
				ST_SOURCE:
					if (src_done)
						state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		in_real_r <= in_real;
		in_imag_r <= in_imag;
	end

	// Pass read data reaches the core one cycle after the read
	always_ff @(posedge clk) begin
		if (!rst_n)
			core_in_valid <= 1'b0;
		else
			core_in_valid <= pa_rd_en;
	end

	// ------------------------------------------------------------
	// RAM port switches
	// ------------------------------------------------------------
	always_comb begin
		if (state == ST_SINK) begin
			ram_wr_en   = sink_wr_en;
			ram_wr_addr = sink_wr_addr;
			ram_wr_data = {{(`MRD_DATA_W-`MRD_IN_W){in_real_r[`MRD_IN_W-1]}}, in_real_r,
				{(`MRD_DATA_W-`MRD_IN_W){in_imag_r[`MRD_IN_W-1]}}, in_imag_r};
		end else begin
			ram_wr_en   = pa_wr_en && core_out_valid;
			ram_wr_addr = pa_wr_addr;
			ram_wr_data = {core_out_real, core_out_imag};
		end
		ram_rd_en   = (state == ST_SOURCE) ? src_rd_en : pa_rd_en;
		ram_rd_addr = (state == ST_SOURCE) ? src_rd_addr : pa_rd_addr;
	end

	assign core_in_real = ram_rd_data[2*`MRD_DATA_W-1:`MRD_DATA_W];
	assign core_in_imag = ram_rd_data[`MRD_DATA_W-1:0];
	assign out_real     = ram_rd_data[2*`MRD_DATA_W-1:`MRD_DATA_W];
	assign out_imag     = ram_rd_data[`MRD_DATA_W-1:0];

	// ------------------------------------------------------------
	// Instances
	// ------------------------------------------------------------
	mrd_io_addr io_addr0 (
		.clk(clk), .rst_n(rst_n), .state(state), .in_valid(in_valid_r),
		.num_pts(num_pts), .sink_wr_en(sink_wr_en), .sink_wr_addr(sink_wr_addr),
		.sink_done(sink_done), .sink_abort(sink_abort), .src_rd_en(src_rd_en),
		.src_rd_addr(src_rd_addr), .src_done(src_done), .out_valid(out_valid),
		.out_sop(out_sop), .out_eop(out_eop)
	);

	mrd_pass_addr pass_addr0 (
		.clk(clk), .rst_n(rst_n), .state(state), .num_pts(num_pts),
		.stride(stride), .radix(core_radix), .rd_en(pa_rd_en),
		.rd_addr(pa_rd_addr), .rd_done(pa_rd_done), .wr_en(pa_wr_en),
		.wr_addr(pa_wr_addr), .wr_done(pa_wr_done)
	);

	mrd_ram ram0 (
		.clk(clk), .wr_en(ram_wr_en), .wr_addr(ram_wr_addr), .wr_data(ram_wr_data),
		.rd_en(ram_rd_en), .rd_addr(ram_rd_addr), .rd_data(ram_rd_data)
	);

endmodule

`default_nettype wire

// ==== hdl/mrd_top.sv ====
// Top level of the mixed-radix transform processor
// Memory controller and radix-2/4 core

`timescale 1ns/1ps
`default_nettype none

`include "mrd_macros.svh"

module mrd_top import mrd_pkg::*; (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          in_sop,
	input  wire                          in_valid,
	input  wire  [`MRD_IN_W-1:0]         in_real,
	input  wire  [`MRD_IN_W-1:0]         in_imag,
	input  wire  [1:0]                   cfg_num_pass,
	input  wire  [2:0]                   cfg_radix,
	output logic                         sink_ready,
	output mrd_state_e                   state,
	output logic                         out_valid,
	output logic                         out_sop,
	output logic                         out_eop,
	output logic [`MRD_DATA_W-1:0]       out_real,
	output logic [`MRD_DATA_W-1:0]       out_imag
);

	// Controller to core
	logic                   core_in_valid;
	logic [`MRD_DATA_W-1:0] core_in_real, core_in_imag;
	mrd_radix_e             core_radix;
	// Core back to controller
	logic                   core_out_valid;
	logic [`MRD_DATA_W-1:0] core_out_real, core_out_imag;

	mrd_mem_ctrl mem_ctrl0 (
		.clk(clk), .rst_n(rst_n), .in_sop(in_sop), .in_valid(in_valid),
		.in_real(in_real), .in_imag(in_imag), .cfg_num_pass(cfg_num_pass),
		.cfg_radix(cfg_radix), .sink_ready(sink_ready), .state(state),
		.core_in_valid(core_in_valid), .core_in_real(core_in_real),
		.core_in_imag(core_in_imag), .core_radix(core_radix),
		.core_out_valid(core_out_valid), .core_out_real(core_out_real),
		.core_out_imag(core_out_imag), .out_valid(out_valid), .out_sop(out_sop),
		.out_eop(out_eop), .out_real(out_real), .out_imag(out_imag)
	);

	mrd_rdx24_core core0 (
		.clk(clk), .rst_n(rst_n), .radix(core_radix), .in_valid(core_in_valid),
		.in_real(core_in_real), .in_imag(core_in_imag), .out_valid(core_out_valid),
		.out_real(core_out_real), .out_imag(core_out_imag)
	);

endmodule

`default_nettype wire

// ==== tests/mrd_tb_ref.svh ====
// Reference model for the mixed-radix transform testbench
// LCG random source, packet size helper
// Exact integer DFT along each mixed-radix digit, pass by pass

`ifndef MRD_TB_REF_SVH
`define MRD_TB_REF_SVH

// LCG state, seeded at the start of the run
logic [31:0] lcg_state;

// ------------------------------------------------------------
// Random numbers
// ------------------------------------------------------------
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Uniform value in 0 .. n-1 from the upper state bits
function automatic int rand_below(input int n);
	logic [31:0] v;
	v = lcg_next();
	return int'(v[30:16]) % n;
endfunction

// Full-range signed 16-bit sample
function automatic int sample_value();
	logic [31:0] v;
	v = lcg_next();
	return int'($signed(v[31:16]));
endfunction

// ------------------------------------------------------------
// Reference transform
// ------------------------------------------------------------
// N is the product of the radices of the used passes
function automatic int points_of(input int npass, input int rbits);
	int n;
	int k;
	n = 1;
	for (k = 0; k < npass; k++)
		n = n * ((((rbits >> k) & 1) != 0) ? 4 : 2);
	return n;
endfunction

// Pass k is a radix r DFT along digit k, in place
function automatic void ref_transform(inout int re [0:63], inout int im [0:63],
	input int npass, input int rbits);
	int n;
	int stride;
	int r;
	int k;
	int base;
	int d;
	int m;
	int q;
	int acc_re;
	int acc_im;
	int g_re [0:3];
	int g_im [0:3];
	n = points_of(npass, rbits);
	stride = 1;
	for (k = 0; k < npass; k++) begin
		r = (((rbits >> k) & 1) != 0) ? 4 : 2;
		for (base = 0; base < n; base++) begin
			// Group start when digit k of the index is zero
			if (((base / stride) % r) == 0) begin
				for (d = 0; d < r; d++) begin
					g_re[d] = re[base + d * stride];
					g_im[d] = im[base + d * stride];
				end
				for (m = 0; m < r; m++) begin
					acc_re = 0;
					acc_im = 0;
					for (d = 0; d < r; d++) begin
						// Twiddle exp(-j*2*pi*d*m/r) in quarter turns
						q = (d * m * (4 / r)) % 4;
						case (q)
							0: begin
								acc_re += g_re[d];
								acc_im += g_im[d];
							end
							1: begin
								acc_re += g_im[d];
								acc_im -= g_re[d];
							end
							2: begin
								acc_re -= g_re[d];
								acc_im -= g_im[d];
							end
							default: begin
								acc_re -= g_im[d];
								acc_im += g_re[d];
							end
						endcase
					end
					re[base + m * stride] = acc_re;
					im[base + m * stride] = acc_im;
				end
			end
		end
		stride = stride * r;
	end
endfunction

`endif

// ==== tests/tb_mrd_top.sv ====
// Testbench for the mixed-radix transform processor
// Clock, reset, packet stimulus, output compare process
// Stray sop and sink timeout cases, cycle limit, summary

`timescale 1ns/1ps
`default_nettype none

`include "mrd_macros.svh"

module tb_mrd_top import mrd_pkg::*; ();

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_RANDOM   = 14;
	// 20 packets of at most 64 points, about 6 cycles per point
	localparam int CYCLE_LIMIT  = 20 * `MRD_MAX_PTS * 6 + 2000;
	localparam logic [31:0] SEED = 32'h3172f2c3;

	logic                   clk;
	logic                   rst_n;
	logic                   in_sop;
	logic                   in_valid;
	logic [`MRD_IN_W-1:0]   in_real;
	logic [`MRD_IN_W-1:0]   in_imag;
	logic [1:0]             cfg_num_pass;
	logic [2:0]             cfg_radix;
	logic                   sink_ready;
	mrd_state_e             state;
	logic                   out_valid;
	logic                   out_sop;
	logic                   out_eop;
	logic [`MRD_DATA_W-1:0] out_real;
	logic [`MRD_DATA_W-1:0] out_imag;

	// Expected samples in output order, one length per packet
	int exp_re_q [$];
	int exp_im_q [$];
	int exp_len_q [$];
	int pkts_sent;
	int pkts_rcvd;
	int value_errs;
	int proto_errs;
	int cycle_cnt;
	int cur_len;
	int cur_idx;
	bit in_pkt;

	`include "mrd_tb_ref.svh"

	mrd_top dut0 (
		.clk(clk), .rst_n(rst_n), .in_sop(in_sop), .in_valid(in_valid),
		.in_real(in_real), .in_imag(in_imag), .cfg_num_pass(cfg_num_pass),
		.cfg_radix(cfg_radix), .sink_ready(sink_ready), .state(state),
		.out_valid(out_valid), .out_sop(out_sop), .out_eop(out_eop),
		.out_real(out_real), .out_imag(out_imag)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------
	// Error reporting
	// ------------------------------------------------------------
	task automatic report_mismatch(input string msg);
		value_errs++;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic count_protocol_error(input string msg);
		proto_errs++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic print_summary();
		$display("Summary: %0d value mismatches, %0d protocol errors, %0d of %0d packets received",
			value_errs, proto_errs, pkts_rcvd, pkts_sent);
	endtask

	// ------------------------------------------------------------
	// Stimulus, all on the falling edge
	// ------------------------------------------------------------
	task automatic drive_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			in_sop   = 1'b0;
			in_valid = 1'b0;
		end
	endtask

	task automatic drive_sample(input int re, input int im);
		@(negedge clk);
		in_sop   = 1'b0;
		in_valid = 1'b1;
		in_real  = re[`MRD_IN_W-1:0];
		in_imag  = im[`MRD_IN_W-1:0];
	endtask

	// Waits for sink_ready, then sends the sop sample with its config
	task automatic drive_sop(input int npass, input int rbits, input int re, input int im);
		@(negedge clk);
		while (!sink_ready)
			@(negedge clk);
		in_sop       = 1'b1;
		in_valid     = 1'b1;
		in_real      = re[`MRD_IN_W-1:0];
		in_imag      = im[`MRD_IN_W-1:0];
		cfg_num_pass = npass[1:0];
		cfg_radix    = rbits[2:0];
	endtask

	// Full packet, expected results queued before the first sample
	task automatic send_packet(input int npass, input int rbits, input bit gaps);
		int re [0:63];
		int im [0:63];
		int ref_re [0:63];
		int ref_im [0:63];
		int n;
		int k;
		n = points_of(npass, rbits);
		for (k = 0; k < n; k++) begin
			re[k] = sample_value();
			im[k] = sample_value();
		end
		ref_re = re;
		ref_im = im;
		ref_transform(ref_re, ref_im, npass, rbits);
		for (k = 0; k < n; k++) begin
			exp_re_q.push_back(ref_re[k]);
			exp_im_q.push_back(ref_im[k]);
		end
		exp_len_q.push_back(n);
		pkts_sent++;
		drive_sop(npass, rbits, re[0], im[0]);
		for (k = 1; k < n; k++) begin
			// Short input gaps, well under the sink timeout
			if (gaps && rand_below(4) == 0)
				drive_idle(1);
			drive_sample(re[k], im[k]);
		end
		drive_idle(1);
	endtask

	// Packet cut short, nothing expected from it
	task automatic send_truncated(input int npass, input int rbits, input int count);
		int k;
		drive_sop(npass, rbits, sample_value(), sample_value());
		for (k = 1; k < count; k++)
			drive_sample(sample_value(), sample_value());
		drive_idle(1);
	endtask

	// sop with data while the DUT is busy with a packet
	task automatic stray_sop_burst(input int count);
		int k;
		int v;
		for (k = 0; k < count; k++) begin
			@(negedge clk);
			assert (!sink_ready)
				else count_protocol_error("sink_ready high while a packet is in process");
			// A taken sop would have moved the FSM back into sink
			assert (state != ST_SINK)
				else report_mismatch("stray sop started a new sink");
			if (!sink_ready) begin
				v = sample_value();
				in_sop       = 1'b1;
				in_valid     = 1'b1;
				in_real      = v[`MRD_IN_W-1:0];
				in_imag      = v[`MRD_IN_W-1:0];
				cfg_num_pass = 2'd1;
				cfg_radix    = 3'd0;
			end
		end
		drive_idle(1);
	endtask

	task automatic wait_drained();
		while (pkts_rcvd < pkts_sent)
			@(negedge clk);
	endtask

	// ------------------------------------------------------------
	// Compare process, outputs sampled on the falling edge
	// ------------------------------------------------------------
	always @(negedge clk) begin : compare_outputs
		int got_r;
		int got_i;
		int exp_r;
		int exp_i;
		if (rst_n) begin
			assert (out_valid || (!out_sop && !out_eop))
				else count_protocol_error("sop or eop strobe without out_valid");
			// Output samples only come out of the source state
			assert (!out_valid || state == ST_SOURCE)
				else report_mismatch("out_valid while the FSM is not in source");
			if (out_valid && out_sop) begin
				assert (!in_pkt)
					else count_protocol_error("new sop before the eop of the previous packet");
				if (in_pkt) begin
					// Discard what is left of the broken packet
					while (cur_idx < cur_len && exp_re_q.size() > 0) begin
						void'(exp_re_q.pop_front());
						void'(exp_im_q.pop_front());
						cur_idx++;
					end
					pkts_rcvd++;
					in_pkt = 1'b0;
				end
				assert (exp_len_q.size() != 0)
					else count_protocol_error("extra output packet that was never sent");
				if (exp_len_q.size() != 0) begin
					cur_len = exp_len_q.pop_front();
					cur_idx = 0;
					in_pkt  = 1'b1;
				end
			end else if (out_valid) begin
				assert (in_pkt)
					else count_protocol_error("out_valid without a packet in progress");
			end
			if (out_valid && in_pkt) begin
				got_r = int'($signed(out_real));
				got_i = int'($signed(out_imag));
				exp_r = exp_re_q.pop_front();
				exp_i = exp_im_q.pop_front();
				assert (got_r == exp_r && got_i == exp_i)
					else report_mismatch($sformatf(
						"packet %0d point %0d got (%0d, %0d) expected (%0d, %0d)",
						pkts_rcvd, cur_idx, got_r, got_i, exp_r, exp_i));
				if (cur_idx == cur_len - 1) begin
					assert (out_eop)
						else count_protocol_error("missing eop on the last sample of a packet");
					pkts_rcvd++;
					in_pkt = 1'b0;
				end else begin
					assert (!out_eop)
						else count_protocol_error("eop before the last sample of a packet");
					cur_idx++;
				end
			end
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run stopped after %0d clock cycles", cycle_cnt);
			print_summary();
			$display("TEST FAIL");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin
		lcg_state    = SEED;
		rst_n        = 1'b0;
		in_sop       = 1'b0;
		in_valid     = 1'b0;
		in_real      = '0;
		in_imag      = '0;
		cfg_num_pass = 2'd1;
		cfg_radix    = 3'd0;
		pkts_sent    = 0;
		pkts_rcvd    = 0;
		value_errs   = 0;
		proto_errs   = 0;
		cycle_cnt    = 0;
		cur_len      = 0;
		cur_idx      = 0;
		in_pkt       = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		// Idle outputs straight out of reset
		assert (sink_ready && state == ST_IDLE && !out_valid && !out_sop && !out_eop)
			else report_mismatch("outputs not at their reset values");

		// Single pass, radix 2 then radix 4
		send_packet(1, 0, 1'b0);
		send_packet(1, 1, 1'b0);

		// Random pass counts and radices
		for (int i = 0; i < NUM_RANDOM; i++)
			send_packet(1 + rand_below(3), rand_below(8), 1'b1);

		// sop while busy must not start a packet
		send_packet(2, 3, 1'b1);
		stray_sop_burst(4);

		// Abort after a few samples, then a clean packet
		wait_drained();
		send_truncated(3, 7, 5);
		drive_idle(`MRD_SINK_TIMEOUT + 8);
		assert (sink_ready)
			else count_protocol_error("sink_ready still low after the sink timeout");
		assert (state == ST_IDLE)
			else report_mismatch("FSM not back in idle after the sink timeout");
		send_packet(3, 5, 1'b1);

		// Drain, then watch for stray output
		wait_drained();
		drive_idle(20);
		print_summary();
		if (value_errs == 0 && proto_errs == 0 && pkts_rcvd == pkts_sent)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mrd_top.f ====
+incdir+hdl
+incdir+tests
hdl/mrd_pkg.sv
hdl/mrd_ram.sv
hdl/mrd_io_addr.sv
hdl/mrd_pass_addr.sv
hdl/mrd_rdx24_core.sv
hdl/mrd_mem_ctrl.sv
hdl/mrd_top.sv
tests/tb_mrd_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mixed-radix transform testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mrd_top.f --top-module tb_mrd_top \
	--Mdir obj_dir -o tb_mrd_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_mrd_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
